//--- rtl/int_div_settings.svh
//----------------------------------------------------------
// width and iteration settings for the iterative divider
//----------------------------------------------------------

`ifndef INT_DIV_SETTINGS_SVH
`define INT_DIV_SETTINGS_SVH

// operand width and packed {rem, quot} response width
`define DIV_OPND_W 32
`define DIV_RES_W  64

// one restoring step per quotient bit
`define DIV_STEPS  32
`define DIV_CNT_W  6

`endif

//--- rtl/int_div_pkg.sv
//----------------------------------------------------------
// shared types for the iterative integer divider
// function select and the packed response word
//----------------------------------------------------------

`include "int_div_settings.svh"

package int_div_pkg;

  //----------------------------------------------------------
  // request function
  //----------------------------------------------------------

  // unsigned treats both operands as plain magnitudes
  // signed rounds toward zero, remainder follows dividend
  typedef enum logic {
    div_unsigned = 1'b0,
    div_signed   = 1'b1
  } div_fn_e;

  //----------------------------------------------------------
  // response word
  //----------------------------------------------------------

  // remainder sits in the upper half, quotient in the lower
  typedef struct packed {
    logic [`DIV_OPND_W-1:0] rem;
    logic [`DIV_OPND_W-1:0] quot;
  } div_fields_t;

  // same 64 bits seen two ways
  // raw is the word on the port
  // fields is what the datapath builds
  typedef union packed {
    logic [`DIV_RES_W-1:0] raw;
    div_fields_t           fields;
  } div_result_t;

endpackage

//--- rtl/int_div_ctrl.sv
//----------------------------------------------------------
// control FSM for the iterative divider
// sequences load, the step cycles and both handshakes
//----------------------------------------------------------

`include "int_div_settings.svh"

module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  // request and response handshake inputs
  input  logic divreq_val,
  input  logic divresp_rdy,

  // handshake outputs
  output logic divreq_rdy,
  output logic divresp_val,

  // pulses to the datapath
  output logic load,
  output logic step
);

  //----------------------------------------------------------
  // state encoding
  //----------------------------------------------------------

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state;
  logic [1:0] state_next;

  // iteration counter, 0 .. DIV_STEPS-1 while in calc
  logic [`DIV_CNT_W-1:0] count;

  logic req_xfer;
  logic resp_xfer;
  logic last_step;

  //----------------------------------------------------------
  // handshake and pulse decode
  //----------------------------------------------------------

  always_comb begin
    divreq_rdy  = 1'b0;
    divresp_val = 1'b0;
    step        = 1'b0;
    case (state)
      // only idle takes a new request
      ST_IDLE: divreq_rdy = 1'b1;
      // one shift-subtract per calc cycle
      ST_CALC: step = 1'b1;
      // result is stable here until the consumer takes it
      ST_DONE: divresp_val = 1'b1;
      default: divreq_rdy = 1'b0;
    endcase
  end

  // channel transfers
  assign req_xfer  = divreq_val & divreq_rdy;
  assign resp_xfer = divresp_val & divresp_rdy;

  // operands are captured on the request transfer edge
  assign load = req_xfer;

  // counter holds DIV_STEPS-1 during the final iteration
  assign last_step = (count == `DIV_CNT_W'(`DIV_STEPS - 1));

  //----------------------------------------------------------
  // next state
  //----------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_xfer) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // 32nd step edge moves to done
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // back pressure keeps us here
        if (resp_xfer) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  //----------------------------------------------------------
  // state and counter registers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // cleared on load, advances once per step
  // stops at the last value, calc exits on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= '0;
    end else if (step && !last_step) begin
      count <= count + `DIV_CNT_W'(1);
    end
  end

endmodule

//--- rtl/int_div_dpath.sv
//----------------------------------------------------------
// datapath for the iterative divider
// restoring shift-subtract on magnitudes, sign fixed at output
//----------------------------------------------------------

`include "int_div_settings.svh"

module int_div_dpath (
  input  logic clk,
  input  logic reset,

  // control pulses
  input  logic load,
  input  logic step,

  // request operands
  input  int_div_pkg::div_fn_e    divreq_fn,
  input  logic [`DIV_OPND_W-1:0]  divreq_a,
  input  logic [`DIV_OPND_W-1:0]  divreq_b,

  // {rem, quot} response
  output int_div_pkg::div_result_t divresp_result
);

  // remainder/quotient register is 2W+1 wide
  // the extra top bit carries the sign of each trial subtraction
  localparam int W    = `DIV_OPND_W;
  localparam int RQ_W = 2 * `DIV_OPND_W + 1;

  //----------------------------------------------------------
  // request side magnitude
  //----------------------------------------------------------

  logic           a_neg_in;
  logic           b_neg_in;
  logic [W-1:0]   a_mag_in;
  logic [W-1:0]   b_mag_in;

  // sign only counts for a signed request
  assign a_neg_in = (divreq_fn == int_div_pkg::div_signed) && divreq_a[W-1];
  assign b_neg_in = (divreq_fn == int_div_pkg::div_signed) && divreq_b[W-1];

  // two's complement magnitude
  // the most negative value maps to itself, read as unsigned
  assign a_mag_in = a_neg_in ? -divreq_a : divreq_a;
  assign b_mag_in = b_neg_in ? -divreq_b : divreq_b;

  //----------------------------------------------------------
  // captured request state
  //----------------------------------------------------------

  int_div_pkg::div_fn_e fn_reg;
  logic                 a_sign;
  logic                 b_sign;

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg <= int_div_pkg::div_unsigned;
      a_sign <= 1'b0;
      b_sign <= 1'b0;
    end else if (load) begin
      fn_reg <= divreq_fn;
      a_sign <= a_neg_in;
      b_sign <= b_neg_in;
    end
  end

  //----------------------------------------------------------
  // iteration registers
  //----------------------------------------------------------

  // rq_reg  {guard, remainder, quotient}
  // dvs_reg {0, divisor, zeros}, fixed for the whole division
  logic [RQ_W-1:0] rq_reg;
  logic [RQ_W-1:0] dvs_reg;

  logic [RQ_W-1:0] rq_shift;
  logic [RQ_W-1:0] rq_diff;
  logic [RQ_W-1:0] rq_step;

  // one restoring step
  always_comb begin
    rq_shift = rq_reg << 1;
    rq_diff  = rq_shift - dvs_reg;
    if (rq_diff[RQ_W-1]) begin
      // divisor did not fit, restore and shift in 0
      rq_step = {rq_shift[RQ_W-1:1], 1'b0};
    end else begin
      // keep the difference, quotient bit is 1
      rq_step = {rq_diff[RQ_W-1:1], 1'b1};
    end
  end

  // dividend starts in the quotient half
  // after DIV_STEPS steps the remainder has moved up
  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg  <= {{(W + 1){1'b0}}, a_mag_in};
      dvs_reg <= {1'b0, b_mag_in, {W{1'b0}}};
    end else if (step) begin
      rq_reg  <= rq_step;
    end
  end

  // zero divisor needs no special path
  // every trial passes, so quot is all ones and rem is the dividend

  //----------------------------------------------------------
  // sign correction and result packing
  //----------------------------------------------------------

  logic [W-1:0] rem_mag;
  logic [W-1:0] quot_mag;
  logic         quot_neg;
  logic         rem_neg;

  assign rem_mag  = rq_reg[2*W-1:W];
  assign quot_mag = rq_reg[W-1:0];

  // quotient negative when the signs differ
  // remainder takes the dividend sign
  assign quot_neg = (fn_reg == int_div_pkg::div_signed) && (a_sign ^ b_sign);
  assign rem_neg  = (fn_reg == int_div_pkg::div_signed) && a_sign;

  // min / -1 falls out as 0x80000000 with remainder 0
  always_comb begin
    divresp_result.fields.rem  = rem_neg ? -rem_mag : rem_mag;
    divresp_result.fields.quot = quot_neg ? -quot_mag : quot_mag;
  end

endmodule

//--- rtl/int_div_iterative.sv
//----------------------------------------------------------
// iterative 32-bit integer divider
// control FSM plus datapath behind valid/ready ports
//----------------------------------------------------------

`include "int_div_settings.svh"

module int_div_iterative (
  input  logic clk,
  input  logic reset,

  //----------------------------------------------------------
  // request channel
  //----------------------------------------------------------

  input  int_div_pkg::div_fn_e     divreq_fn,
  input  logic [`DIV_OPND_W-1:0]   divreq_a,
  input  logic [`DIV_OPND_W-1:0]   divreq_b,
  input  logic                     divreq_val,
  output logic                     divreq_rdy,

  //----------------------------------------------------------
  // response channel
  //----------------------------------------------------------

  // remainder upper half, quotient lower half
  output int_div_pkg::div_result_t divresp_result,
  output logic                     divresp_val,
  input  logic                     divresp_rdy
);

  // load on the request transfer, step for each iteration
  logic load;
  logic step;

  // handshakes are decided by the FSM only
  int_div_ctrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .divreq_val  (divreq_val),
    .divresp_rdy (divresp_rdy),
    .divreq_rdy  (divreq_rdy),
    .divresp_val (divresp_val),
    .load        (load),
    .step        (step)
  );

  // datapath follows load and step
  // result is valid whenever the FSM sits in done
  int_div_dpath dpath (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .step           (step),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divresp_result (divresp_result)
  );

endmodule

//--- verif/int_div_tb_tasks.svh
//----------------------------------------------------------
// drive, reference model and compare tasks for the divider
//----------------------------------------------------------

task automatic fail_run(input string why);
  $display("%s", why);
  if (req_desc != "") $display("while running %s", req_desc);
  $display("TEST RESULT: FAIL");
  $fatal(1, "stopping at first error");
endtask

task automatic compare_result(input int_div_pkg::div_result_t got,
                              input int_div_pkg::div_result_t exp);
  if (got.raw !== exp.raw) begin
    fail_run($sformatf("mismatch divresp_result: got %h (rem %h quot %h), expected %h (rem %h quot %h)",
                       got.raw, got.fields.rem, got.fields.quot,
                       exp.raw, exp.fields.rem, exp.fields.quot));
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp) fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic compare_count(input string name, input int got, input int exp);
  if (got != exp) fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
endtask

// signed rounds toward zero, remainder follows the dividend
// zero divisor gives all ones over the dividend magnitude
task automatic model_div(input int_div_pkg::div_fn_e fn,
                         input logic [`DIV_OPND_W-1:0] a,
                         input logic [`DIV_OPND_W-1:0] b,
                         output int_div_pkg::div_result_t res);
  logic                   a_neg;
  logic                   b_neg;
  logic [`DIV_OPND_W-1:0] a_mag;
  logic [`DIV_OPND_W-1:0] b_mag;
  logic [`DIV_OPND_W-1:0] q_mag;
  logic [`DIV_OPND_W-1:0] r_mag;
  logic [`DIV_OPND_W-1:0] min_val;
  min_val = '0;
  min_val[`DIV_OPND_W-1] = 1'b1;
  a_neg = (fn == int_div_pkg::div_signed) && a[`DIV_OPND_W-1];
  b_neg = (fn == int_div_pkg::div_signed) && b[`DIV_OPND_W-1];
  a_mag = a_neg ? -a : a;
  b_mag = b_neg ? -b : b;
  if (b == '0) begin
    q_mag = '1;
    r_mag = a_mag;
  end else begin
    q_mag = a_mag / b_mag;
    r_mag = a_mag % b_mag;
  end
  res.fields.quot = (a_neg != b_neg) ? -q_mag : q_mag;
  res.fields.rem  = a_neg ? -r_mag : r_mag;
  // overflow case, most negative over minus one
  if (fn == int_div_pkg::div_signed && a == min_val && b == '1) begin
    res.fields.quot = min_val;
    res.fields.rem  = '0;
  end
endtask

// one division: request, busy wait, then hold divresp_rdy low for hold cycles
// busy keeps divreq_val high with other operands during the calculation
task automatic do_div(input int_div_pkg::div_fn_e fn,
                      input logic [`DIV_OPND_W-1:0] a,
                      input logic [`DIV_OPND_W-1:0] b,
                      input int hold,
                      input bit busy,
                      output int_div_pkg::div_result_t res,
                      output int lat);
  int_div_pkg::div_result_t first;
  int                       i;
  @(negedge clk);
  divreq_fn   = fn;
  divreq_a    = a;
  divreq_b    = b;
  divreq_val  = 1'b1;
  divresp_rdy = 1'b0;
  while (!divreq_rdy) @(negedge clk);
  // request transfer edge
  @(posedge clk);
  @(negedge clk);
  if (busy) begin
    divreq_fn = (fn == int_div_pkg::div_signed) ? int_div_pkg::div_unsigned
                                                : int_div_pkg::div_signed;
    divreq_a  = ~a;
    divreq_b  = b + 32'd3;
  end else begin
    divreq_val = 1'b0;
  end
  lat = 0;
  while (!divresp_val) begin
    compare_flag("divreq_rdy", divreq_rdy, 1'b0);
    lat++;
    @(negedge clk);
  end
  compare_flag("divreq_rdy", divreq_rdy, 1'b0);
  first = divresp_result;
  // back-pressure, response must hold still
  for (i = 0; i < hold; i++) begin
    @(negedge clk);
    compare_flag("divresp_val", divresp_val, 1'b1);
    compare_flag("divreq_rdy", divreq_rdy, 1'b0);
    compare_result(divresp_result, first);
  end
  divresp_rdy = 1'b1;
  @(negedge clk);
  divreq_val  = 1'b0;
  divresp_rdy = 1'b0;
  // response went on the first edge with ready high
  compare_flag("divresp_val", divresp_val, 1'b0);
  compare_flag("divreq_rdy", divreq_rdy, 1'b1);
  res = first;
endtask

task automatic check_div(input int_div_pkg::div_fn_e fn,
                         input logic [`DIV_OPND_W-1:0] a,
                         input logic [`DIV_OPND_W-1:0] b,
                         input int hold,
                         input bit busy);
  int_div_pkg::div_result_t got;
  int_div_pkg::div_result_t exp;
  int                       lat;
  req_desc = $sformatf("%s divide a=%h b=%h", fn.name(), a, b);
  do_div(fn, a, b, hold, busy, got, lat);
  model_div(fn, a, b, exp);
  compare_result(got, exp);
  compare_count("latency", lat, exp_latency);
endtask

//----------------------------------------------------------
// directed and random tests
//----------------------------------------------------------

task automatic test_unsigned();
  check_div(fn_u, 32'd100, 32'd7, 0, 1'b0);
  // dividend below divisor
  check_div(fn_u, 32'd7, 32'd100, 0, 1'b0);
  check_div(fn_u, 32'hffff_ffff, 32'hffff_ffff, 0, 1'b0);
  check_div(fn_u, 32'hffff_ffff, 32'd1, 0, 1'b0);
  check_div(fn_u, 32'hffff_ffff, 32'h0001_0000, 1, 1'b0);
  check_div(fn_u, 32'h1234_5678, 32'h0000_9abc, 0, 1'b0);
  check_div(fn_u, 32'd0, 32'd5, 0, 1'b0);
endtask

task automatic test_signed();
  // inexact, all four sign combinations
  check_div(fn_s, 32'd7, 32'd2, 0, 1'b0);
  check_div(fn_s, -32'd7, 32'd2, 0, 1'b0);
  check_div(fn_s, 32'd7, -32'd2, 1, 1'b0);
  check_div(fn_s, -32'd7, -32'd2, 0, 1'b0);
  // exact
  check_div(fn_s, 32'd20, 32'd5, 0, 1'b0);
  check_div(fn_s, -32'd20, 32'd5, 0, 1'b0);
  check_div(fn_s, 32'd20, -32'd5, 2, 1'b0);
  check_div(fn_s, -32'd20, -32'd5, 0, 1'b0);
  check_div(fn_s, 32'h8000_0000, 32'd3, 0, 1'b0);
  check_div(fn_s, 32'h7fff_ffff, -32'd1, 0, 1'b0);
endtask

task automatic test_special();
  // zero divisor
  check_div(fn_s, 32'd5, 32'd0, 0, 1'b0);
  check_div(fn_s, -32'd5, 32'd0, 0, 1'b0);
  check_div(fn_u, 32'd5, 32'd0, 0, 1'b0);
  check_div(fn_u, 32'hffff_fffb, 32'd0, 0, 1'b0);
  check_div(fn_s, 32'h8000_0000, 32'd0, 0, 1'b0);
  check_div(fn_u, 32'd0, 32'd0, 0, 1'b0);
  // overflow and its unsigned bit pattern
  check_div(fn_s, 32'h8000_0000, 32'hffff_ffff, 0, 1'b0);
  check_div(fn_u, 32'h8000_0000, 32'hffff_ffff, 0, 1'b0);
endtask

// request stays valid while busy, must not be taken early
task automatic test_busy();
  check_div(fn_u, 32'h0bad_cafe, 32'd13, 0, 1'b1);
  check_div(fn_s, -32'd1000, 32'd7, 0, 1'b1);
endtask

task automatic test_backpressure();
  check_div(fn_u, 32'd999, 32'd10, 1, 1'b0);
  check_div(fn_s, -32'd999, 32'd10, 3, 1'b0);
  check_div(fn_s, 32'd999, -32'd10, 5, 1'b1);
endtask

task automatic test_random();
  int                     i;
  int                     hold;
  bit                     busy;
  int_div_pkg::div_fn_e   fn;
  logic [`DIV_OPND_W-1:0] a;
  logic [`DIV_OPND_W-1:0] b;
  for (i = 0; i < num_random; i++) begin
    fn = ($urandom_range(0, 1) == 1) ? fn_s : fn_u;
    a  = $urandom;
    // mix of small, medium and full width divisors
    case ($urandom_range(0, 3))
      0:       b = $urandom_range(0, 15);
      1:       b = $urandom_range(0, 32'hffff);
      default: b = $urandom;
    endcase
    hold = $urandom_range(0, 4);
    busy = ($urandom_range(0, 1) == 1);
    check_div(fn, a, b, hold, busy);
  end
endtask

//--- verif/int_div_tb.sv
//----------------------------------------------------------
// testbench for the iterative integer divider
// directed and random divisions against a reference model
//----------------------------------------------------------

`include "int_div_settings.svh"

module int_div_tb;

  //----------------------------------------------------------
  // run constants
  //----------------------------------------------------------

  localparam int          reset_cycles = 10;
  localparam int          num_directed = 30;
  localparam int          num_random   = 200;
  localparam logic [31:0] seed         = 32'ha122;

  // 40 cycles per division covers 33 cycles of latency plus response stalls
  localparam int timeout_cycles = (num_directed + num_random) * 40 + reset_cycles + 200;

  // negedges with divresp_val low after the request transfer
  localparam int exp_latency = `DIV_STEPS;

  localparam int_div_pkg::div_fn_e fn_u = int_div_pkg::div_unsigned;
  localparam int_div_pkg::div_fn_e fn_s = int_div_pkg::div_signed;

  //----------------------------------------------------------
  // DUT signals
  //----------------------------------------------------------

  logic                     clk;
  logic                     reset;
  int_div_pkg::div_fn_e     divreq_fn;
  logic [`DIV_OPND_W-1:0]   divreq_a;
  logic [`DIV_OPND_W-1:0]   divreq_b;
  logic                     divreq_val;
  logic                     divreq_rdy;
  int_div_pkg::div_result_t divresp_result;
  logic                     divresp_val;
  logic                     divresp_rdy;

  // current request, printed with any failure
  string req_desc = "";
  int    cycle_count = 0;

  int_div_iterative UUT (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (divreq_fn),
    .divreq_a       (divreq_a),
    .divreq_b       (divreq_b),
    .divreq_val     (divreq_val),
    .divreq_rdy     (divreq_rdy),
    .divresp_result (divresp_result),
    .divresp_val    (divresp_val),
    .divresp_rdy    (divresp_rdy)
  );

  `include "int_div_tb_tasks.svh"

  // period 4
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // global limit so a stuck handshake cannot hang the run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run($sformatf("timeout: run did not finish within %0d cycles", timeout_cycles));
    end
  end

  //----------------------------------------------------------
  // test sequence
  //----------------------------------------------------------

  initial begin
    void'($urandom(seed));
    reset       = 1'b1;
    divreq_fn   = fn_u;
    divreq_a    = '0;
    divreq_b    = '0;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // idle after reset
    compare_flag("divreq_rdy", divreq_rdy, 1'b1);
    compare_flag("divresp_val", divresp_val, 1'b0);

    test_unsigned();
    test_signed();
    test_special();
    test_busy();
    test_backpressure();
    test_random();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- files.f
+incdir+rtl
+incdir+verif
rtl/int_div_pkg.sv
rtl/int_div_ctrl.sv
rtl/int_div_dpath.sv
rtl/int_div_iterative.sv
verif/int_div_tb.sv

//--- run.sh
#!/bin/sh
# build the divider testbench with Verilator and run it
# the simulator exit status is the result of the run
cd "$(dirname "$0")" &&
  verilator --binary -j 0 --top-module int_div_tb -Mdir obj_dir -f files.f &&
  ./obj_dir/Vint_div_tb ||
  exit 1
